// ==== logic/regex_pkg.sv ====
package regex_pkg;

    //////////////////////////////
    // widths

    localparam int reg_width      = 32;
    localparam int wr_width       = 32; // write word, also the decoded word
    localparam int wr_addr_width  = 10;
    localparam int rd_width       = 64; // read line
    localparam int rd_addr_width  = 9;
    localparam int word_sel_width = 1;  // half of a read line
    localparam int pc_width       = 8;
    localparam int char_width     = 8;
    localparam int byte_sel_width = 2;  // character inside a word
    localparam int op_width       = 8;

    //////////////////////////////
    // host command and status codes

    localparam logic [reg_width-1:0] cmd_nop          = 32'd0;
    localparam logic [reg_width-1:0] cmd_write        = 32'd1;
    localparam logic [reg_width-1:0] cmd_read         = 32'd2;
    localparam logic [reg_width-1:0] cmd_start        = 32'd3;
    localparam logic [reg_width-1:0] cmd_restart      = 32'd4;
    localparam logic [reg_width-1:0] cmd_read_elapsed = 32'd5;
    localparam logic [reg_width-1:0] cmd_reset        = 32'd6;

    localparam logic [reg_width-1:0] status_idle     = 32'd0;
    localparam logic [reg_width-1:0] status_running  = 32'd1;
    localparam logic [reg_width-1:0] status_accepted = 32'd2;
    localparam logic [reg_width-1:0] status_rejected = 32'd3;
    localparam logic [reg_width-1:0] status_error    = 32'd4;

    // opcodes, anything else faults
    localparam logic [op_width-1:0] op_char   = 8'd1;
    localparam logic [op_width-1:0] op_any    = 8'd2;
    localparam logic [op_width-1:0] op_jmp    = 8'd3;
    localparam logic [op_width-1:0] op_accept = 8'd4;

    // engine states
    localparam int eng_state_width = 3;
    localparam logic [eng_state_width-1:0] eng_idle       = 3'd0;
    localparam logic [eng_state_width-1:0] eng_fetch      = 3'd1;
    localparam logic [eng_state_width-1:0] eng_decode     = 3'd2;
    localparam logic [eng_state_width-1:0] eng_char_fetch = 3'd3;
    localparam logic [eng_state_width-1:0] eng_compare    = 3'd4;

    // one ram word, read as an instruction or as four characters
    typedef union packed {
        struct packed {
            logic [op_width-1:0]                                  opcode;
            logic [char_width-1:0]                                literal;
            logic [pc_width-1:0]                                  target;
            logic [wr_width-op_width-char_width-pc_width-1:0]     spare;
        } instr;
        logic [wr_width/char_width-1:0][char_width-1:0] chars; // chars[0] is the low byte
    } mem_word_t;

endpackage

// ==== logic/dual_width_bram.sv ====
`timescale 1ns/1ps

module dual_width_bram (
    input  logic                                clk,
    input  logic                                core_rst,
    input  logic [regex_pkg::wr_addr_width-1:0] w_addr,
    input  logic [regex_pkg::wr_width-1:0]      w_data,
    input  logic                                w_en,
    input  logic [regex_pkg::rd_addr_width-1:0] r_addr,
    input  logic                                r_en,
    output logic [regex_pkg::rd_width-1:0]      r_data
);
    import regex_pkg::*;

    logic [wr_width-1:0] mem [0:(1<<wr_addr_width)-1];

    // contents survive a core reset
    always_ff @(posedge clk)
    begin
        if (w_en)
        begin
            mem[w_addr] <= w_data;
        end
    end

    // registered line, held while nobody reads
    always_ff @(posedge clk)
    begin
        if (core_rst)
        begin
            r_data <= '0;
        end
        else if (r_en)
        begin
            r_data <= {mem[{r_addr, 1'b1}], mem[{r_addr, 1'b0}]}; // odd word on top
        end
    end

endmodule

// ==== logic/command_front.sv ====
`timescale 1ns/1ps

module command_front (
    input  logic                                clk,
    input  logic                                rst_master,
    input  logic [regex_pkg::reg_width-1:0]     data_in_register,
    input  logic [regex_pkg::reg_width-1:0]     address_register,
    input  logic [regex_pkg::reg_width-1:0]     start_cc_pointer_register,
    input  logic [regex_pkg::reg_width-1:0]     end_cc_pointer_register,
    input  logic [regex_pkg::reg_width-1:0]     cmd_register,
    output logic [regex_pkg::reg_width-1:0]     status_register,
    output logic [regex_pkg::reg_width-1:0]     data_o_register,
    output logic                                core_rst,
    output logic [regex_pkg::wr_addr_width-1:0] w_addr,
    output logic [regex_pkg::wr_width-1:0]      w_data,
    output logic                                w_en,
    output logic [regex_pkg::rd_addr_width-1:0] r_addr,
    output logic                                r_en,
    input  logic [regex_pkg::rd_width-1:0]      r_data,
    output logic                                start_valid,
    input  logic                                start_ready,
    input  logic [regex_pkg::rd_addr_width-1:0] mem_addr,
    input  logic                                mem_valid,
    output logic                                mem_ready,
    input  logic                                done,
    input  logic                                accept,
    input  logic                                fault
);
    import regex_pkg::*;

    logic [reg_width-1:0]      status_next;
    logic [reg_width-1:0]      elapsed;
    logic [reg_width-1:0]      elapsed_next;
    logic [word_sel_width-1:0] word_sel;

    assign core_rst = rst_master || (cmd_register == cmd_reset);
    assign word_sel = address_register[word_sel_width-1:0]; // half of the read line

    always_ff @(posedge clk)
    begin
        if (core_rst)
        begin
            status_register <= status_idle;
            elapsed         <= '0;
        end
        else
        begin
            status_register <= status_next;
            elapsed         <= elapsed_next;
        end
    end

    //////////////////////////////
    // command decode per status

    always_comb
    begin
        status_next     = status_register;
        elapsed_next    = elapsed;
        data_o_register = '0;
        w_addr          = '0;
        w_data          = '0;
        w_en            = 1'b0;
        r_addr          = '0;
        r_en            = 1'b0;
        mem_ready       = 1'b0;
        start_valid     = 1'b0;

        case (status_register)
            status_idle, status_accepted, status_rejected, status_error:
            begin
                case (cmd_register)
                    cmd_write:
                    begin
                        w_addr = address_register[wr_addr_width-1:0];
                        w_data = data_in_register[wr_width-1:0];
                        w_en   = 1'b1;
                    end
                    cmd_read:
                    begin
                        r_addr          = address_register[word_sel_width +: rd_addr_width];
                        r_en            = 1'b1;
                        data_o_register = r_data[word_sel * wr_width +: wr_width]; // valid a cycle later
                    end
                    cmd_read_elapsed: data_o_register = elapsed;
                    cmd_start:
                    begin
                        if (status_register == status_idle) // only from idle
                        begin
                            start_valid  = 1'b1;
                            r_addr       = mem_addr;
                            r_en         = mem_valid;
                            mem_ready    = 1'b1;
                            if (start_ready)
                            begin
                                status_next  = status_running;
                                elapsed_next = '0;
                            end
                        end
                    end
                    cmd_restart:
                    begin
                        if (status_register != status_idle)
                        begin
                            status_next = status_idle;
                        end
                    end
                    default: ;
                endcase
            end
            status_running:
            begin
                // engine owns the read port
                r_addr    = mem_addr;
                r_en      = mem_valid;
                mem_ready = 1'b1;
                if (fault)
                begin
                    status_next = status_error;
                end
                else if (done)
                begin
                    status_next = accept ? status_accepted : status_rejected;
                end
                if (~&elapsed)
                begin
                    elapsed_next = elapsed + 1'b1; // saturating
                end
            end
            default: status_next = status_idle;
        endcase
    end

endmodule

// ==== logic/regex_engine.sv ====
`timescale 1ns/1ps

module regex_engine (
    input  logic                                clk,
    input  logic                                core_rst,
    input  logic                                start_valid,
    output logic                                start_ready,
    input  logic [regex_pkg::reg_width-1:0]     start_cc_pointer,
    input  logic [regex_pkg::reg_width-1:0]     end_cc_pointer,
    output logic [regex_pkg::rd_addr_width-1:0] mem_addr,
    output logic                                mem_valid,
    input  logic                                mem_ready,
    input  logic [regex_pkg::rd_width-1:0]      mem_data,
    output logic                                done,
    output logic                                accept,
    output logic                                fault
);
    import regex_pkg::*;

    logic [eng_state_width-1:0] state;
    logic [eng_state_width-1:0] state_next;
    logic [pc_width-1:0]        pc;
    logic [pc_width-1:0]        pc_next;
    logic [reg_width-1:0]       ptr;
    logic [reg_width-1:0]       ptr_next;
    logic [reg_width-1:0]       end_ptr;
    logic [reg_width-1:0]       end_next;
    mem_word_t                  instr_q;
    mem_word_t                  instr_next;
    mem_word_t                  fetch_word;
    mem_word_t                  char_word;
    logic [char_width-1:0]      cur_char;
    logic                       exhausted;

    // the same line read two ways
    assign fetch_word = mem_data[pc[word_sel_width-1:0] * wr_width +: wr_width];
    assign char_word  = mem_data[ptr[byte_sel_width +: word_sel_width] * wr_width +: wr_width];
    assign cur_char   = char_word.chars[ptr[byte_sel_width-1:0]];
    assign exhausted  = ptr > end_ptr; // end pointer is the last character

    always_ff @(posedge clk)
    begin
        if (core_rst)
        begin
            state <= eng_idle;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_ff @(posedge clk)
    begin
        pc      <= pc_next;
        ptr     <= ptr_next;
        end_ptr <= end_next;
        instr_q <= instr_next;
    end

    //////////////////////////////
    // interpreter

    always_comb
    begin
        state_next  = state;
        pc_next     = pc;
        ptr_next    = ptr;
        end_next    = end_ptr;
        instr_next  = instr_q;
        start_ready = (state == eng_idle);
        mem_valid   = 1'b0;
        mem_addr    = '0;
        done        = 1'b0;
        accept      = 1'b0;
        fault       = 1'b0;

        case (state)
            eng_idle:
            begin
                if (start_valid)
                begin
                    pc_next    = '0;
                    ptr_next   = start_cc_pointer;
                    end_next   = end_cc_pointer;
                    state_next = eng_fetch;
                end
            end
            eng_fetch:
            begin
                mem_valid = 1'b1;
                mem_addr  = rd_addr_width'(pc[pc_width-1:word_sel_width]); // two instrs per line
                if (mem_ready)
                begin
                    state_next = eng_decode;
                end
            end
            eng_decode:
            begin
                instr_next = fetch_word; // keep it, the line gets replaced
                case (fetch_word.instr.opcode)
                    op_char, op_any:
                    begin
                        if (exhausted)
                        begin
                            done       = 1'b1; // out of text, reject
                            state_next = eng_idle;
                        end
                        else
                        begin
                            state_next = eng_char_fetch;
                        end
                    end
                    op_jmp:
                    begin
                        pc_next    = fetch_word.instr.target;
                        state_next = eng_fetch;
                    end
                    op_accept:
                    begin
                        done       = 1'b1;
                        accept     = 1'b1;
                        state_next = eng_idle;
                    end
                    default:
                    begin
                        done       = 1'b1;
                        fault      = 1'b1;
                        state_next = eng_idle;
                    end
                endcase
            end
            eng_char_fetch:
            begin
                mem_valid = 1'b1;
                mem_addr  = ptr[byte_sel_width+word_sel_width +: rd_addr_width];
                if (mem_ready)
                begin
                    state_next = eng_compare;
                end
            end
            eng_compare:
            begin
                if (instr_q.instr.opcode == op_any || cur_char == instr_q.instr.literal)
                begin
                    pc_next    = pc + 1'b1;
                    ptr_next   = ptr + 1'b1;
                    state_next = eng_fetch;
                end
                else
                begin
                    done       = 1'b1; // mismatch
                    state_next = eng_idle;
                end
            end
            default: state_next = eng_idle;
        endcase
    end

endmodule

// ==== logic/regex_accel_top.sv ====
`timescale 1ns/1ps

module regex_accel_top (
    input  logic                            clk,
    input  logic                            rst_master,
    input  logic [regex_pkg::reg_width-1:0] data_in_register,
    input  logic [regex_pkg::reg_width-1:0] address_register,
    input  logic [regex_pkg::reg_width-1:0] start_cc_pointer_register,
    input  logic [regex_pkg::reg_width-1:0] end_cc_pointer_register,
    input  logic [regex_pkg::reg_width-1:0] cmd_register,
    output logic [regex_pkg::reg_width-1:0] status_register,
    output logic [regex_pkg::reg_width-1:0] data_o_register
);
    import regex_pkg::*;

    logic                     core_rst;
    logic [wr_addr_width-1:0] w_addr;
    logic [wr_width-1:0]      w_data;
    logic                     w_en;
    logic [rd_addr_width-1:0] r_addr;
    logic                     r_en;
    logic [rd_width-1:0]      r_data;      // also the engine's mem_data
    logic                     start_valid;
    logic                     start_ready;
    logic [rd_addr_width-1:0] mem_addr;
    logic                     mem_valid;
    logic                     mem_ready;
    logic                     done;
    logic                     accept;
    logic                     fault;

    //////////////////////////////
    // front end, ram, engine

    command_front u_front (
        .clk                       (clk),
        .rst_master                (rst_master),
        .data_in_register          (data_in_register),
        .address_register          (address_register),
        .start_cc_pointer_register (start_cc_pointer_register),
        .end_cc_pointer_register   (end_cc_pointer_register),
        .cmd_register              (cmd_register),
        .status_register           (status_register),
        .data_o_register           (data_o_register),
        .core_rst                  (core_rst),
        .w_addr                    (w_addr),
        .w_data                    (w_data),
        .w_en                      (w_en),
        .r_addr                    (r_addr),
        .r_en                      (r_en),
        .r_data                    (r_data),
        .start_valid               (start_valid),
        .start_ready               (start_ready),
        .mem_addr                  (mem_addr),
        .mem_valid                 (mem_valid),
        .mem_ready                 (mem_ready),
        .done                      (done),
        .accept                    (accept),
        .fault                     (fault)
    );

    dual_width_bram u_bram (
        .clk      (clk),
        .core_rst (core_rst),
        .w_addr   (w_addr),
        .w_data   (w_data),
        .w_en     (w_en),
        .r_addr   (r_addr),
        .r_en     (r_en),
        .r_data   (r_data)
    );

    regex_engine u_engine (
        .clk              (clk),
        .core_rst         (core_rst),
        .start_valid      (start_valid),
        .start_ready      (start_ready),
        .start_cc_pointer (start_cc_pointer_register), // sampled at start
        .end_cc_pointer   (end_cc_pointer_register),
        .mem_addr         (mem_addr),
        .mem_valid        (mem_valid),
        .mem_ready        (mem_ready),
        .mem_data         (r_data),
        .done             (done),
        .accept           (accept),
        .fault            (fault)
    );

endmodule

// ==== verification/regex_accel_tb.sv ====
`timescale 1ns/1ps

module regex_accel_tb;
    import regex_pkg::*;

    localparam int poll_limit  = 200;   // cycles
    localparam int text_base   = 2048;  // byte address above the program
    localparam int watchdog_ns = 20000;

    logic                 clk;
    logic                 rst_master;
    logic [reg_width-1:0] data_in_register;
    logic [reg_width-1:0] address_register;
    logic [reg_width-1:0] start_cc_pointer_register;
    logic [reg_width-1:0] end_cc_pointer_register;
    logic [reg_width-1:0] cmd_register;
    logic [reg_width-1:0] status_register;
    logic [reg_width-1:0] data_o_register;
    int                   seed = 32'hdd1a;

    regex_accel_top u_dut (
        .clk                       (clk),
        .rst_master                (rst_master),
        .data_in_register          (data_in_register),
        .address_register          (address_register),
        .start_cc_pointer_register (start_cc_pointer_register),
        .end_cc_pointer_register   (end_cc_pointer_register),
        .cmd_register              (cmd_register),
        .status_register           (status_register),
        .data_o_register           (data_o_register)
    );

    always #4 clk = ~clk;

    initial
    begin
        #(watchdog_ns);
        $display("watchdog expired, the tests did not finish in %0d ns", watchdog_ns);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog");
    end

    //////////////////////////////
    // checks

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("STATUS: FAIL");
        $fatal(1, "first error");
    endtask

    task automatic check_status(input string name, input logic [reg_width-1:0] expected,
                                input logic [reg_width-1:0] actual);
        if (actual !== expected)
        begin
            stop_on_error($sformatf("mismatch in %s: expected status %0d, actual %0d",
                                    name, expected, actual));
        end
    endtask

    task automatic check_word(input string name, input logic [reg_width-1:0] expected,
                              input logic [reg_width-1:0] actual);
        if (actual !== expected)
        begin
            stop_on_error($sformatf("mismatch in %s: expected %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    task automatic check_instr(input string name, input mem_word_t expected,
                               input mem_word_t actual);
        if (actual !== expected)
        begin
            stop_on_error($sformatf("mismatch in %s: expected instr %h, actual %h",
                                    name, expected, actual));
        end
    endtask

    //////////////////////////////
    // host accesses

    task automatic step_cycle();
        @(posedge clk);
        #1; // drive point
    endtask

    task automatic send_cmd(input logic [reg_width-1:0] cmd);
        cmd_register = cmd;
        step_cycle();
        cmd_register = cmd_nop;
    endtask

    task automatic write_word(input logic [reg_width-1:0] addr, input logic [reg_width-1:0] data);
        address_register = addr;
        data_in_register = data;
        send_cmd(cmd_write);
    endtask

    task automatic read_word(input logic [reg_width-1:0] addr, output logic [reg_width-1:0] data);
        address_register = addr;
        cmd_register     = cmd_read;
        step_cycle();                // line registered at this edge
        data             = data_o_register;
        cmd_register     = cmd_nop;
    endtask

    task automatic read_elapsed(output logic [reg_width-1:0] value);
        cmd_register = cmd_read_elapsed;
        step_cycle();
        value        = data_o_register;
        cmd_register = cmd_nop;
    endtask

    task automatic start_run(input int first, input int last);
        start_cc_pointer_register = first;
        end_cc_pointer_register   = last;
        send_cmd(cmd_start);
    endtask

    task automatic wait_finished(input string name, output logic [reg_width-1:0] final_status);
        int cycles;
        cycles = 0;
        while (status_register == status_running && cycles < poll_limit)
        begin
            step_cycle();
            cycles++;
        end
        if (status_register == status_running)
        begin
            stop_on_error($sformatf("%s: the run never left running within %0d cycles",
                                    name, poll_limit));
        end
        final_status = status_register;
    endtask

    function automatic mem_word_t make_instr(input logic [op_width-1:0] opcode,
                                             input logic [char_width-1:0] literal,
                                             input logic [pc_width-1:0] target);
        mem_word_t w;
        w              = '0;
        w.instr.opcode  = opcode;
        w.instr.literal = literal;
        w.instr.target  = target;
        return w;
    endfunction

    // text bytes packed little end first with unused bytes zero
    task automatic place_text(input int base, input string s);
        mem_word_t w;
        int        p;
        for (int a = base / 4; a <= (base + s.len() - 1) / 4; a++)
        begin
            w = '0;
            for (int b = 0; b < 4; b++)
            begin
                p = a * 4 + b - base;
                if (p >= 0 && p < s.len())
                begin
                    w.chars[b] = s[p];
                end
            end
            write_word(a, w);
        end
    endtask

    task automatic run_match(input string name, input int first, input int last,
                             input logic [reg_width-1:0] exp_status,
                             input logic [reg_width-1:0] exp_elapsed);
        logic [reg_width-1:0] st;
        logic [reg_width-1:0] elapsed;
        start_run(first, last);
        check_status({name, " start"}, status_running, status_register);
        wait_finished(name, st);
        check_status(name, exp_status, st);
        read_elapsed(elapsed);
        check_word({name, " elapsed"}, exp_elapsed, elapsed);
    endtask

    task automatic restart_to_idle(input string name);
        send_cmd(cmd_restart);
        check_status({name, " restart"}, status_idle, status_register);
    endtask

    //////////////////////////////
    // directed tests

    task automatic test_mem_round_trip();
        logic [reg_width-1:0] model [0:1023];
        int                   addrs[$];
        int                   line;
        logic [reg_width-1:0] value;
        for (int i = 0; i < 8; i++)
        begin
            line = $random(seed) & 511;
            for (int h = 0; h < 2; h++)  // both halves of the line
            begin
                value                = $random(seed);
                model[line * 2 + h]  = value;
                addrs.push_back(line * 2 + h);
                write_word(line * 2 + h, value);
            end
        end
        foreach (addrs[i])
        begin
            read_word(addrs[i], value);
            check_word($sformatf("mem_round_trip word %0d", addrs[i]), model[addrs[i]], value);
        end
    endtask

    task automatic test_literal_match();
        write_word(0, make_instr(op_char, "a", 0));
        write_word(1, make_instr(op_char, "b", 0));
        write_word(2, make_instr(op_accept, 0, 0));
        place_text(text_base, "ab");
        run_match("literal_match", text_base, text_base + 1, status_accepted, 10);
        restart_to_idle("literal_match");
    endtask

    task automatic test_mismatch_exhaustion();
        write_word(1, make_instr(op_char, "c", 0));
        run_match("mismatch", text_base, text_base + 1, status_rejected, 8);
        restart_to_idle("mismatch");
        write_word(1, make_instr(op_char, "b", 0));
        write_word(2, make_instr(op_char, "c", 0));
        write_word(3, make_instr(op_accept, 0, 0));
        run_match("exhaustion", text_base, text_base + 1, status_rejected, 10);
        restart_to_idle("exhaustion");
    endtask

    task automatic test_jump_wildcard();
        write_word(0, make_instr(op_any, 0, 0));
        write_word(1, make_instr(op_jmp, 0, 3));
        write_word(2, 32'h0);                    // never reached
        write_word(3, make_instr(op_accept, 0, 0));
        place_text(text_base + 13, "wxyz");      // runs into the next line
        run_match("jump_wildcard", text_base + 13, text_base + 16, status_accepted, 8);
        restart_to_idle("jump_wildcard");
    endtask

    task automatic test_fault_control();
        logic [reg_width-1:0] value;
        write_word(0, 32'h0);
        run_match("fault", text_base, text_base + 1, status_error, 2);
        send_cmd(cmd_start);
        check_status("start in error", status_error, status_register);
        restart_to_idle("fault");
        send_cmd(cmd_restart);
        check_status("restart in idle", status_idle, status_register);
        write_word(0, make_instr(op_accept, 0, 0));
        run_match("run after restart", text_base, text_base + 1, status_accepted, 2);
        send_cmd(cmd_reset);
        check_status("core reset", status_idle, status_register);
        read_elapsed(value);
        check_word("core reset elapsed", 0, value);
        read_word(0, value);
        check_instr("ram after core reset", make_instr(op_accept, 0, 0), value);
    endtask

    initial
    begin
        clk                       = 1'b0;
        rst_master                = 1'b1;
        data_in_register          = '0;
        address_register          = '0;
        start_cc_pointer_register = '0;
        end_cc_pointer_register   = '0;
        cmd_register              = cmd_nop;
        repeat (16) @(posedge clk);
        #1;
        rst_master = 1'b0;

        test_mem_round_trip();
        test_literal_match();
        test_mismatch_exhaustion();
        test_jump_wildcard();
        test_fault_control();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== regex_accel_top.f ====
logic/regex_pkg.sv
logic/dual_width_bram.sv
logic/command_front.sv
logic/regex_engine.sv
logic/regex_accel_top.sv
verification/regex_accel_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the regex accelerator testbench with verilator

set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log
sim_bin=regex_accel_sim

verilator --binary --timing -Wno-fatal -f regex_accel_top.f \
    --top-module regex_accel_tb -Mdir "$build_dir" -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^STATUS: PASS$" "$log_file"; then
    echo "simulation passed"
    exit 0
fi
echo "pass message not found in $log_file"
exit 1
